// ==== eeprom_ctrl_top.f ====
rtl/eeprom_pkg.sv
rtl/i2c_cmd_if.sv
rtl/i2c_bit_engine.sv
rtl/eeprom_wr.sv
rtl/eeprom_ctrl_top.sv
dv/eeprom_model.sv
dv/eeprom_checker.sv
dv/tb_eeprom_ctrl.sv

// ==== dv/tb_eeprom_ctrl.sv ====
`timescale 1ns/10ps

module tb_eeprom_ctrl import eeprom_pkg::*; ();

  localparam int CLK_DIV    = 4;
  localparam int BIT_CYCLES = 4 * CLK_DIV;

  typedef struct packed {
    logic                     is_rd;
    logic [EEPROM_ADDR_W-1:0] addr;
    logic [7:0]               wdata;
    logic                     model_en;
    logic                     exp_nack;
  } stim_t;

  logic                     clk;
  logic                     reset;
  logic                     wr;
  logic                     rd;
  logic [EEPROM_ADDR_W-1:0] addr;
  logic [7:0]               wdata;
  logic [7:0]               rdata;
  logic                     ack;
  logic                     nack;
  logic                     scl;
  wire                      sda;
  logic                     model_en;
  logic                     exp_nack;
  int                       test_cnt;
  int                       err_cnt;
  stim_t                    tbl[$];
  bit                       table_ready = 1'b0;
  integer                   seed = 32'hab6cc0ed;

  pullup (sda);

  eeprom_ctrl_top #(
    .CLK_DIV (CLK_DIV)
  ) i_eeprom_ctrl_top (
    .clk   (clk),
    .reset (reset),
    .wr    (wr),
    .rd    (rd),
    .addr  (addr),
    .wdata (wdata),
    .rdata (rdata),
    .ack   (ack),
    .nack  (nack),
    .scl   (scl),
    .sda   (sda)
  );

  eeprom_model i_eeprom_model (
    .scl (scl),
    .sda (sda),
    .en  (model_en)
  );

  eeprom_checker i_eeprom_checker (
    .clk      (clk),
    .reset    (reset),
    .wr       (wr),
    .rd       (rd),
    .addr     (addr),
    .wdata    (wdata),
    .rdata    (rdata),
    .ack      (ack),
    .nack     (nack),
    .exp_nack (exp_nack),
    .test_cnt (test_cnt),
    .err_cnt  (err_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic add_entry(logic is_rd, logic [EEPROM_ADDR_W-1:0] a, logic [7:0] d,
                           logic en, logic exp_n);
    stim_t s;
    s.is_rd    = is_rd;
    s.addr     = a;
    s.wdata    = d;
    s.model_en = en;
    s.exp_nack = exp_n;
    tbl.push_back(s);
  endtask

  task automatic build_table();
    logic [31:0] r;
    add_entry(0, 11'h123, 8'ha5, 1, 0);   // write then read back
    add_entry(1, 11'h123, 8'h00, 1, 0);
    add_entry(0, 11'h045, 8'h11, 1, 0);   // same word in other blocks
    add_entry(0, 11'h745, 8'h22, 1, 0);
    add_entry(0, 11'h345, 8'h33, 1, 0);
    add_entry(1, 11'h045, 8'h00, 1, 0);
    add_entry(1, 11'h745, 8'h00, 1, 0);
    add_entry(1, 11'h345, 8'h00, 1, 0);
    add_entry(0, 11'h123, 8'hc3, 1, 0);   // overwrite
    add_entry(1, 11'h123, 8'h00, 1, 0);
    add_entry(1, 11'h2f0, 8'h00, 1, 0);   // never written
    add_entry(1, 11'h6ff, 8'h00, 1, 0);
    add_entry(0, 11'h400, 8'h77, 0, 1);   // no slave on the bus
    add_entry(1, 11'h400, 8'h00, 0, 1);
    add_entry(1, 11'h400, 8'h00, 1, 0);
    for (int i = 0; i < 10; i++) begin
      r = $random(seed);
      add_entry(0, r[10:0], r[23:16], 1, 0);
      add_entry(1, r[10:0], 8'h00, 1, 0);
    end
  endtask

  task automatic run_entry(stim_t s);
    @(posedge clk);
    #2;
    model_en = s.model_en;
    exp_nack = s.exp_nack;
    addr     = s.addr;
    wdata    = s.wdata;
    wr       = !s.is_rd;
    rd       = s.is_rd;
    do begin
      @(posedge clk);
      #2;
    end while (ack !== 1'b1);
    @(posedge clk);   // drop the request the cycle after ack
    #2;
    wr = 1'b0;
    rd = 1'b0;
  endtask

  initial begin
    reset    = 1'b1;
    wr       = 1'b0;
    rd       = 1'b0;
    addr     = '0;
    wdata    = 8'h00;
    model_en = 1'b1;
    exp_nack = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge clk);
    #2 reset = 1'b0;
    foreach (tbl[i])
      run_entry(tbl[i]);
    repeat (4) @(posedge clk);
    if (test_cnt != tbl.size())
      $display("saw %0d acks for %0d table entries", test_cnt, tbl.size());
    $display("tests %0d, passed %0d, failed %0d", tbl.size(), test_cnt - err_cnt, err_cnt);
    if (err_cnt == 0 && test_cnt == tbl.size())
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  // 40 bit periods per entry covers the longest transaction with margin
  initial begin
    wait (table_ready);
    #(tbl.size() * 40 * BIT_CYCLES * 40 * 2);
    $display("timeout: the controller stopped answering requests");
    $display("** FAIL **");
    $finish;
  end

endmodule

// ==== dv/eeprom_checker.sv ====
`timescale 1ns/10ps

module eeprom_checker import eeprom_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     wr,
  input  logic                     rd,
  input  logic [EEPROM_ADDR_W-1:0] addr,
  input  logic [7:0]               wdata,
  input  logic [7:0]               rdata,
  input  logic                     ack,
  input  logic                     nack,
  input  logic                     exp_nack,
  output int                       test_cnt,
  output int                       err_cnt
);

  logic [7:0] shadow [0:(1 << EEPROM_ADDR_W) - 1];

  initial begin
    test_cnt = 0;
    err_cnt  = 0;
    for (int a = 0; a < (1 << EEPROM_ADDR_W); a++)
      shadow[a] = 8'(a) ^ 8'h5a;   // same image as the eeprom model
  end

  // request is still held during the ack cycle
  always @(posedge clk) begin
    logic [7:0] exp_data;
    if (!reset && ack === 1'b1) begin
      exp_data = shadow[addr];
      test_cnt++;
      if (!(wr || rd)) begin
        err_cnt++;
        $display("test %0d: ack arrived with no request pending", test_cnt);
      end else if (nack !== exp_nack) begin
        err_cnt++;
        $display("FAILED nack exp %h got %h (test %0d, addr %h)",
                 exp_nack, nack, test_cnt, addr);
      end else if (!wr && !nack && rdata !== exp_data) begin
        err_cnt++;
        $display("FAILED rdata exp %h got %h (test %0d, addr %h)",
                 exp_data, rdata, test_cnt, addr);
      end else begin
        $display("test %0d ok: %s addr %h data %h nack %0d", test_cnt,
                 wr ? "write" : "read ", addr, wr ? wdata : rdata, nack);
      end
      if (wr && nack === 1'b0)
        shadow[addr] = wdata;
    end
  end

endmodule

// ==== dv/eeprom_model.sv ====
`timescale 1ns/10ps

module eeprom_model import eeprom_pkg::*; (
  input logic scl,
  inout wire  sda,
  input logic en     // low: never acknowledges
);

  typedef enum logic [2:0] {
    p_idle,
    p_ctrl,
    p_word,
    p_data,
    p_rd_ack,
    p_read
  } phase_e;

  logic [7:0]               mem [0:(1 << EEPROM_ADDR_W) - 1];
  phase_e                   phase = p_idle;
  logic [3:0]               bit_cnt = 4'd0;   // scl rises seen in this byte
  logic [7:0]               sr;
  logic [7:0]               dout;
  logic [2:0]               blk;
  logic [EEPROM_ADDR_W-1:0] ptr;
  logic                     sda_low = 1'b0;

  assign sda = sda_low ? 1'b0 : 1'bz;

  initial begin
    for (int a = 0; a < (1 << EEPROM_ADDR_W); a++)
      mem[a] = 8'(a) ^ 8'h5a;
  end

  // start or restart
  always @(negedge sda) begin
    if (scl === 1'b1) begin
      phase   = p_ctrl;
      bit_cnt = 4'd0;
      sda_low = 1'b0;
    end
  end

  always @(posedge sda) begin
    if (scl === 1'b1) begin   // stop
      phase   = p_idle;
      bit_cnt = 4'd0;
    end
  end

  always @(posedge scl) begin
    if (phase != p_idle) begin
      if (bit_cnt < 4'd8)
        sr = {sr[6:0], sda};
      bit_cnt = bit_cnt + 4'd1;
    end
  end

  // sda only moves while scl is low
  always @(negedge scl) begin
    if (bit_cnt == 4'd8) begin
      case (phase)
        p_ctrl: begin
          if (en && sr[7:4] == EEPROM_DEV_TYPE) begin
            sda_low = 1'b1;
            blk     = sr[3:1];
            phase   = sr[0] ? p_rd_ack : p_word;
          end else begin
            phase = p_idle;   // not addressed, stay off the bus
          end
        end
        p_word: begin
          sda_low = 1'b1;
          ptr     = {blk, sr};
          phase   = p_data;
        end
        p_data: begin
          sda_low  = 1'b1;
          mem[ptr] = sr;      // write cycle done at once
        end
        default: sda_low = 1'b0;   // master ack slot
      endcase
    end else if (bit_cnt == 4'd9) begin
      sda_low = 1'b0;
      bit_cnt = 4'd0;
      if (phase == p_rd_ack) begin
        phase   = p_read;
        dout    = mem[ptr];
        sda_low = !dout[7];
      end else if (phase == p_read) begin
        phase = p_idle;       // single byte read only
      end
    end else if (phase == p_read && bit_cnt != 4'd0) begin
      sda_low = !dout[3'd7 - bit_cnt[2:0]];
    end
  end

endmodule

// ==== rtl/eeprom_ctrl_top.sv ====
`timescale 1ns/10ps

module eeprom_ctrl_top import eeprom_pkg::*; #(
  parameter int CLK_DIV = 4    // clk cycles per quarter scl period
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     wr,
  input  logic                     rd,
  input  logic [EEPROM_ADDR_W-1:0] addr,
  input  logic [7:0]               wdata,
  output logic [7:0]               rdata,
  output logic                     ack,
  output logic                     nack,
  output logic                     scl,
  inout  wire                      sda
);

  i2c_cmd_if i_cmd_if ();

  eeprom_wr i_eeprom_wr (
    .clk   (clk),
    .reset (reset),
    .wr    (wr),
    .rd    (rd),
    .addr  (addr),
    .wdata (wdata),
    .rdata (rdata),
    .ack   (ack),
    .nack  (nack),
    .cmd   (i_cmd_if.sequencer)
  );

  i2c_bit_engine #(
    .CLK_DIV (CLK_DIV)
  ) i_i2c_bit_engine (
    .clk   (clk),
    .reset (reset),
    .scl   (scl),
    .sda   (sda),
    .cmd   (i_cmd_if.engine)
  );

endmodule

// ==== rtl/eeprom_wr.sv ====
`timescale 1ns/10ps

module eeprom_wr import eeprom_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     wr,
  input  logic                     rd,
  input  logic [EEPROM_ADDR_W-1:0] addr,
  input  logic [7:0]               wdata,
  output logic [7:0]               rdata,
  output logic                     ack,
  output logic                     nack,
  i2c_cmd_if.sequencer             cmd
);

  // one hot main states
  localparam logic [9:0] idle        = 10'b00_0000_0001;
  localparam logic [9:0] write_start = 10'b00_0000_0010;
  localparam logic [9:0] ctrl_write  = 10'b00_0000_0100;
  localparam logic [9:0] addr_write  = 10'b00_0000_1000;
  localparam logic [9:0] data_write  = 10'b00_0001_0000;
  localparam logic [9:0] read_start  = 10'b00_0010_0000;
  localparam logic [9:0] ctrl_read   = 10'b00_0100_0000;
  localparam logic [9:0] data_read   = 10'b00_1000_0000;
  localparam logic [9:0] stop        = 10'b01_0000_0000;
  localparam logic [9:0] ackn        = 10'b10_0000_0000;

  logic [9:0]               state;
  logic [9:0]               nxt;
  logic [EEPROM_ADDR_W-1:0] addr_q;
  logic [7:0]               wdata_q;
  logic                     is_read;
  ctrl_byte_u               ctrl;

  always_comb begin
    ctrl.fields.dev_type = EEPROM_DEV_TYPE;
    ctrl.fields.block    = addr_q[EEPROM_ADDR_W-1 -: 3];
    ctrl.fields.rw       = (state == ctrl_read);
  end

  // command and byte follow the state, so they hold until transfer
  always_comb begin
    cmd.cmd     = cmd_write;
    cmd.tx_byte = ctrl.raw;
    case (state)
      write_start: cmd.cmd = cmd_start;
      read_start:  cmd.cmd = cmd_restart;
      addr_write:  cmd.tx_byte = addr_q[7:0];
      data_write:  cmd.tx_byte = wdata_q;
      data_read:   cmd.cmd = cmd_read_nack;
      stop:        cmd.cmd = cmd_stop;
      default: ;
    endcase
  end

  always_comb begin
    nxt = state;
    case (state)
      idle:        if (wr || rd) nxt = write_start;
      write_start: if (cmd.done) nxt = ctrl_write;
      ctrl_write:  if (cmd.done) nxt = cmd.slave_nack ? stop : addr_write;
      addr_write: begin
        if (cmd.done)
          nxt = cmd.slave_nack ? stop : (is_read ? read_start : data_write);
      end
      data_write:  if (cmd.done) nxt = stop;
      read_start:  if (cmd.done) nxt = ctrl_read;  // random read turns around here
      ctrl_read:   if (cmd.done) nxt = cmd.slave_nack ? stop : data_read;
      data_read:   if (cmd.done) nxt = stop;
      stop:        if (cmd.done) nxt = ackn;
      default:     nxt = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= idle;
      cmd.cmd_valid <= 1'b0;
      ack           <= 1'b0;
      nack          <= 1'b0;
      rdata         <= 8'h00;
      is_read       <= 1'b0;
    end else begin
      state <= nxt;
      ack   <= (nxt == ackn);
      if (cmd.cmd_valid && cmd.cmd_ready)
        cmd.cmd_valid <= 1'b0;
      if (nxt != state && nxt != ackn && nxt != idle)
        cmd.cmd_valid <= 1'b1;    // one command per state
      if (state == idle && (wr || rd)) begin
        is_read <= !wr;           // wr wins
        nack    <= 1'b0;
      end
      if (cmd.done && cmd.slave_nack)
        nack <= 1'b1;
      if (state == data_read && cmd.done)
        rdata <= cmd.rx_byte;
    end
  end

  always_ff @(posedge clk) begin
    if (state == idle) begin
      addr_q  <= addr;
      wdata_q <= wdata;
    end
  end

  a_ack_pulse: assert property (@(posedge clk) disable iff (reset) ack |=> !ack);

  // request held until the engine takes it
  a_cmd_hold: assert property (
    @(posedge clk) disable iff (reset)
      (cmd.cmd_valid && !cmd.cmd_ready)
      |=> (cmd.cmd_valid && $stable(cmd.cmd) && $stable(cmd.tx_byte))
  );

endmodule

// ==== rtl/i2c_bit_engine.sv ====
`timescale 1ns/10ps

module i2c_bit_engine import eeprom_pkg::*; #(
  parameter int CLK_DIV = 4
) (
  input  logic      clk,
  input  logic      reset,
  output logic      scl,
  inout  wire       sda,
  i2c_cmd_if.engine cmd
);

  localparam int QW = $clog2(CLK_DIV);

  logic [QW-1:0] qcnt;
  logic [1:0]    phase;      // quarter of the current bit
  logic [3:0]    bit_cnt;
  logic          busy;
  bus_cmd_e      cmd_q;
  logic [7:0]    tx_shift;
  logic [7:0]    rx_shift;
  logic          sda_oe;
  logic          sda_in;

  logic          xfer;
  logic          tick;
  logic          byte_cmd;
  logic          last_phase;
  logic [1:0]    phase_n;
  logic [3:0]    bit_n;
  logic [1:0]    drv_xfer;
  logic [1:0]    drv_tick;

  // open drain, pulled up outside
  assign sda    = sda_oe ? 1'b0 : 1'bz;
  assign sda_in = sda;

  assign cmd.cmd_ready = !busy;
  assign cmd.rx_byte   = rx_shift;

  assign xfer       = cmd.cmd_valid && cmd.cmd_ready;
  assign tick       = busy && (qcnt == QW'(CLK_DIV - 1));
  assign byte_cmd   = (cmd_q == cmd_write) || (cmd_q == cmd_read_nack);
  assign last_phase = (phase == 2'd3) && (bit_cnt == (byte_cmd ? 4'd8 : 4'd0));
  assign phase_n    = phase + 2'd1;
  assign bit_n      = (phase == 2'd3) ? bit_cnt + 4'd1 : bit_cnt;

  // scl and sda drive for the quarter being entered
  // phases 0,1 scl low and 2,3 high, data moves at entry of phase 1
  function automatic logic [1:0] drive(bus_cmd_e c, logic [1:0] ph, logic [3:0] bn,
                                       logic tx_bit, logic oe_now);
    logic s;
    logic oe;
    s  = (ph >= 2'd2);
    oe = oe_now;
    case (c)
      cmd_start: begin
        s  = 1'b1;              // scl stays high coming from idle
        oe = (ph >= 2'd2);      // sda falls mid bit
      end
      cmd_restart: begin
        s  = (ph != 2'd0);
        oe = (ph >= 2'd2);
      end
      cmd_stop: begin
        if (ph != 2'd0)
          oe = (ph != 2'd3);    // sda rises with scl high
      end
      cmd_write: begin
        if (ph != 2'd0)
          oe = (bn != 4'd8) && !tx_bit;   // bit 8 released for slave ack
      end
      default: begin
        if (ph != 2'd0)
          oe = 1'b0;            // read bits and our nack
      end
    endcase
    return {s, oe};
  endfunction

  assign drv_xfer = drive(cmd.cmd, 2'd0, 4'd0, cmd.tx_byte[7], sda_oe);
  assign drv_tick = drive(cmd_q, phase_n, bit_n, tx_shift[7], sda_oe);

  always_ff @(posedge clk) begin
    if (reset) begin
      busy           <= 1'b0;
      qcnt           <= '0;
      phase          <= 2'd0;
      bit_cnt        <= 4'd0;
      cmd_q          <= cmd_start;
      scl            <= 1'b1;
      sda_oe         <= 1'b0;
      cmd.done       <= 1'b0;
      cmd.slave_nack <= 1'b0;
    end else begin
      cmd.done <= 1'b0;
      if (xfer) begin
        busy           <= 1'b1;
        cmd_q          <= cmd.cmd;
        qcnt           <= '0;
        phase          <= 2'd0;
        bit_cnt        <= 4'd0;
        cmd.slave_nack <= 1'b0;
        {scl, sda_oe}  <= drv_xfer;
      end else if (busy) begin
        qcnt <= tick ? '0 : qcnt + 1'b1;
        if (tick) begin
          if (last_phase) begin
            busy     <= 1'b0;   // lines hold their level while idle
            cmd.done <= 1'b1;
          end else begin
            phase         <= phase_n;
            bit_cnt       <= bit_n;
            {scl, sda_oe} <= drv_tick;
          end
          // ack sampled mid high
          if (phase == 2'd2 && cmd_q == cmd_write && bit_cnt == 4'd8)
            cmd.slave_nack <= sda_in;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (xfer)
      tx_shift <= cmd.tx_byte;
    else if (tick && phase == 2'd3)
      tx_shift <= {tx_shift[6:0], 1'b0};
    if (tick && phase == 2'd2 && cmd_q == cmd_read_nack && bit_cnt != 4'd8)
      rx_shift <= {rx_shift[6:0], sda_in};
  end

  // sda may only move under scl high for start, restart and stop
  a_sda_stable: assert property (
    @(posedge clk) disable iff (reset)
      (scl && $past(scl) && !(busy && cmd_q inside {cmd_start, cmd_restart, cmd_stop}))
      |-> $stable(sda_oe)
  );

endmodule

// ==== rtl/i2c_cmd_if.sv ====
`timescale 1ns/10ps

interface i2c_cmd_if import eeprom_pkg::*; ();

  logic       cmd_valid;
  bus_cmd_e   cmd;
  logic [7:0] tx_byte;

  logic       cmd_ready;   // engine idle
  logic       done;        // one cycle at end of command
  logic [7:0] rx_byte;
  logic       slave_nack;  // ack bit of the last write was high

  modport sequencer (
    output cmd_valid,
    output cmd,
    output tx_byte,
    input  cmd_ready,
    input  done,
    input  rx_byte,
    input  slave_nack
  );

  modport engine (
    input  cmd_valid,
    input  cmd,
    input  tx_byte,
    output cmd_ready,
    output done,
    output rx_byte,
    output slave_nack
  );

endinterface

// ==== rtl/eeprom_pkg.sv ====
package eeprom_pkg;

  // 24c16 style part: 3 block bits on the bus, 8 word bits in the address byte
  localparam int EEPROM_ADDR_W = 11;

  localparam logic [3:0] EEPROM_DEV_TYPE = 4'b1010;

  // commands from the sequencer to the bit engine
  typedef enum logic [2:0] {
    cmd_start     = 3'd0,
    cmd_restart   = 3'd1,
    cmd_write     = 3'd2,  // 8 bits out, slave ack in
    cmd_read_nack = 3'd3,  // 8 bits in, master nack out
    cmd_stop      = 3'd4
  } bus_cmd_e;

  // first byte after a start
  typedef union packed {
    logic [7:0] raw;       // shifted out msb first
    struct packed {
      logic [3:0] dev_type;
      logic [2:0] block;   // addr[10:8]
      logic       rw;      // 1 = read
    } fields;
  } ctrl_byte_u;

endpackage
